// File: compile.f
+incdir+tb
logic/dpc_pkg.sv
logic/trace_alloc.sv
logic/trace_entry.sv
logic/hazard_check.sv
logic/dpc_monitor.sv
tb/tb_dpc_monitor.sv

// File: logic/dpc_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module dpc_monitor (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              sys_reset_req,
	input  logic                              flush_req,
	// instruction enters the fetch queue
	input  logic                              enter_valid,
	input  logic [dpc_pkg::INST_ID_WIDTH-1:0] enter_inst_id,
	input  logic [dpc_pkg::REG_ID_WIDTH-1:0]  enter_rd_id,
	input  logic                              enter_rd_vld,
	input  logic                              enter_is_long,
	// instruction leaves dispatch
	input  logic                              dsptc_valid,
	input  logic [dpc_pkg::INST_ID_WIDTH-1:0] dsptc_inst_id,
	// instruction retires
	input  logic                              retire_valid,
	input  logic [dpc_pkg::INST_ID_WIDTH-1:0] retire_inst_id,
	// decode RAW and dispatch WAW queries
	input  logic [dpc_pkg::REG_ID_WIDTH-1:0]  rs1_id,
	input  logic [dpc_pkg::REG_ID_WIDTH-1:0]  rs2_id,
	input  logic [dpc_pkg::REG_ID_WIDTH-1:0]  waw_rd_id,
	output logic                              rs1_raw_dpc,
	output logic                              rs2_raw_dpc,
	output logic                              rd_waw_dpc,
	output logic                              tb_full
);
	import dpc_pkg::*;

	logic [TRACE_N-1:0]                   alloc_sel; // one-hot slot for the entering instruction
	logic [TRACE_N-1:0]                   slot_busy;
	logic [TRACE_N-1:0]                   slot_dispatched;
	logic [TRACE_N-1:0][REG_ID_WIDTH-1:0] slot_rd_id;
	logic [TRACE_N-1:0]                   slot_rd_vld;
	logic [TRACE_N-1:0]                   slot_is_long;

	trace_alloc i_alloc (
		.enter_valid (enter_valid),
		.slot_busy   (slot_busy),
		.alloc_sel   (alloc_sel),
		.tb_full     (tb_full)
	);

	// event buses go to every slot, each slot matches its own id
	for (genvar i = 0; i < TRACE_N; i++) begin : g_entry
		trace_entry i_entry (
			.clk             (clk),
			.reset           (reset),
			.sys_reset_req   (sys_reset_req),
			.flush_req       (flush_req),
			.alloc           (alloc_sel[i]),
			.enter_inst_id   (enter_inst_id),
			.enter_rd_id     (enter_rd_id),
			.enter_rd_vld    (enter_rd_vld),
			.enter_is_long   (enter_is_long),
			.dsptc_valid     (dsptc_valid),
			.dsptc_inst_id   (dsptc_inst_id),
			.retire_valid    (retire_valid),
			.retire_inst_id  (retire_inst_id),
			.slot_busy       (slot_busy[i]),
			.slot_dispatched (slot_dispatched[i]),
			.slot_rd_id      (slot_rd_id[i]),
			.slot_rd_vld     (slot_rd_vld[i]),
			.slot_is_long    (slot_is_long[i])
		);
	end

	hazard_check i_hazard (
		.rs1_id          (rs1_id),
		.rs2_id          (rs2_id),
		.waw_rd_id       (waw_rd_id),
		.slot_dispatched (slot_dispatched),
		.slot_rd_id      (slot_rd_id),
		.slot_rd_vld     (slot_rd_vld),
		.slot_is_long    (slot_is_long),
		.rs1_raw_dpc     (rs1_raw_dpc),
		.rs2_raw_dpc     (rs2_raw_dpc),
		.rd_waw_dpc      (rd_waw_dpc)
	);

endmodule

`default_nettype wire

// File: logic/dpc_pkg.sv
`default_nettype none

package dpc_pkg;

	// table geometry
	localparam int TRACE_N = 4; // instructions tracked between fetch and retire
	localparam int TRACE_IDX_WIDTH = 2; // enough bits to number every slot

	// instruction ids come from the fetch unit and wrap around
	localparam int INST_ID_WIDTH = 4;

	// general register file
	localparam int REG_ID_WIDTH = 5; // x0..x31
	localparam logic [REG_ID_WIDTH-1:0] REG_ZERO = '0; // x0 reads as zero, never a hazard

endpackage

`default_nettype wire

// File: logic/hazard_check.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_check (
	input  logic [dpc_pkg::REG_ID_WIDTH-1:0]                       rs1_id,
	input  logic [dpc_pkg::REG_ID_WIDTH-1:0]                       rs2_id,
	input  logic [dpc_pkg::REG_ID_WIDTH-1:0]                       waw_rd_id,
	input  logic [dpc_pkg::TRACE_N-1:0]                            slot_dispatched,
	input  logic [dpc_pkg::TRACE_N-1:0][dpc_pkg::REG_ID_WIDTH-1:0] slot_rd_id,
	input  logic [dpc_pkg::TRACE_N-1:0]                            slot_rd_vld,
	input  logic [dpc_pkg::TRACE_N-1:0]                            slot_is_long,
	output logic                                                   rs1_raw_dpc,
	output logic                                                   rs2_raw_dpc,
	output logic                                                   rd_waw_dpc
);
	import dpc_pkg::*;

	logic [TRACE_N-1:0] writer_vld; // dispatched and will write rd
	logic [TRACE_N-1:0] rs1_hit;
	logic [TRACE_N-1:0] rs2_hit;
	logic [TRACE_N-1:0] waw_hit;

	assign writer_vld = slot_dispatched & slot_rd_vld;

	// per-slot compare against the three query ports
	always_comb begin
		for (int i = 0; i < TRACE_N; i++) begin
			rs1_hit[i] = writer_vld[i] && (slot_rd_id[i] == rs1_id);
			rs2_hit[i] = writer_vld[i] && (slot_rd_id[i] == rs2_id);
			// short ops complete in order, so only long ones can be overtaken
			waw_hit[i] = writer_vld[i] && slot_is_long[i] && (slot_rd_id[i] == waw_rd_id);
		end
	end

	// x0 is never written, so queries on it are always clear
	assign rs1_raw_dpc = (|rs1_hit) && (rs1_id != REG_ZERO);
	assign rs2_raw_dpc = (|rs2_hit) && (rs2_id != REG_ZERO);
	assign rd_waw_dpc = (|waw_hit) && (waw_rd_id != REG_ZERO);

endmodule

`default_nettype wire

// File: logic/trace_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module trace_alloc (
	input  logic                       enter_valid,
	input  logic [dpc_pkg::TRACE_N-1:0] slot_busy,
	output logic [dpc_pkg::TRACE_N-1:0] alloc_sel,
	output logic                       tb_full
);
	import dpc_pkg::*;

	logic [TRACE_IDX_WIDTH-1:0] free_idx; // lowest free slot
	logic                       free_found;

	// priority search where slot 0 wins
	always_comb begin
		free_idx = '0;
		free_found = 1'b0;
		for (int i = TRACE_N - 1; i >= 0; i--) begin
			if (!slot_busy[i]) begin
				free_idx = TRACE_IDX_WIDTH'(i);
				free_found = 1'b1;
			end
		end
	end

	// one-hot steer of the entering instruction
	always_comb begin
		alloc_sel = '0;
		if (enter_valid && free_found) begin
			alloc_sel = TRACE_N'(1) << free_idx;
		end
	end

	assign tb_full = &slot_busy; // fetch side must hold off entries

	// the fetch side is expected to watch tb_full before it enters
	always_comb begin
		assert final (!(enter_valid && tb_full))
			else $error("enter while trace table full");
	end

endmodule

`default_nettype wire

// File: logic/trace_entry.sv
`timescale 1ns/1ns
`default_nettype none

module trace_entry (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               sys_reset_req,
	input  logic                               flush_req,
	input  logic                               alloc,
	input  logic [dpc_pkg::INST_ID_WIDTH-1:0]  enter_inst_id,
	input  logic [dpc_pkg::REG_ID_WIDTH-1:0]   enter_rd_id,
	input  logic                               enter_rd_vld,
	input  logic                               enter_is_long,
	input  logic                               dsptc_valid,
	input  logic [dpc_pkg::INST_ID_WIDTH-1:0]  dsptc_inst_id,
	input  logic                               retire_valid,
	input  logic [dpc_pkg::INST_ID_WIDTH-1:0]  retire_inst_id,
	output logic                               slot_busy,
	output logic                               slot_dispatched,
	output logic [dpc_pkg::REG_ID_WIDTH-1:0]   slot_rd_id,
	output logic                               slot_rd_vld,
	output logic                               slot_is_long
);
	import dpc_pkg::*;

	logic [INST_ID_WIDTH-1:0] inst_id; // id of the tracked instruction
	logic                     dsptc_hit;
	logic                     retire_hit;
	logic                     flush_hit;

	// stale ids in a free slot must not match
	assign dsptc_hit = dsptc_valid && slot_busy && (dsptc_inst_id == inst_id);
	assign retire_hit = retire_valid && slot_busy && (retire_inst_id == inst_id);

	// only pending slots are squashed, dispatched ones run to retirement
	assign flush_hit = flush_req && slot_busy && !slot_dispatched;

	always_ff @(posedge clk) begin
		if (reset || sys_reset_req) begin
			slot_busy <= 1'b0;
			slot_dispatched <= 1'b0;
		end else if (flush_hit) begin
			slot_busy <= 1'b0;
		end else if (retire_hit) begin
			slot_busy <= 1'b0;
			slot_dispatched <= 1'b0; // keeps dispatched implying busy
		end else if (dsptc_hit) begin
			slot_dispatched <= 1'b1;
		end else if (alloc && !flush_req) begin // enter during flush is dropped
			slot_busy <= 1'b1;
			slot_dispatched <= 1'b0;
		end
	end

	// payload, only meaningful while busy
	always_ff @(posedge clk) begin
		if (alloc) begin
			inst_id <= enter_inst_id;
			slot_rd_id <= enter_rd_id;
			slot_rd_vld <= enter_rd_vld;
			slot_is_long <= enter_is_long;
		end
	end

	// allocator must only pick this slot while it is free
	a_alloc_free: assert property (@(posedge clk) disable iff (reset)
		alloc |-> !slot_busy)
		else $error("allocation into a busy slot");

	// in-order dispatch issues each instruction once
	a_dsptc_once: assert property (@(posedge clk) disable iff (reset)
		dsptc_hit |-> !slot_dispatched)
		else $error("second dispatch of a tracked instruction");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the dpc_monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_dpc_monitor \
	-o sim_dpc_monitor

output=$(./obj_dir/sim_dpc_monitor 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'Everything OK'; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: tb/dpc_model.svh
`ifndef DPC_MODEL_SVH
`define DPC_MODEL_SVH

// reference copy of the trace table, one bit or field per slot
logic [TRACE_N-1:0]       m_busy;
logic [TRACE_N-1:0]       m_disp;
logic [TRACE_N-1:0]       m_rd_vld;
logic [TRACE_N-1:0]       m_long;
logic [INST_ID_WIDTH-1:0] m_id [TRACE_N];
logic [REG_ID_WIDTH-1:0]  m_rd [TRACE_N];

function automatic void model_reset();
	m_busy = '0;
	m_disp = '0;
	m_rd_vld = '0;
	m_long = '0;
	for (int i = 0; i < TRACE_N; i++) begin
		m_id[i] = '0;
		m_rd[i] = '0;
	end
endfunction

// state after one rising edge with the given inputs
function automatic void model_edge(input logic clear, input logic flush,
		input logic ent, input logic [INST_ID_WIDTH-1:0] ent_id,
		input logic [REG_ID_WIDTH-1:0] ent_rd, input logic ent_rd_vld, input logic ent_long,
		input logic dsp, input logic [INST_ID_WIDTH-1:0] dsp_id,
		input logic ret, input logic [INST_ID_WIDTH-1:0] ret_id);
	int free_slot;
	free_slot = -1;
	for (int i = TRACE_N - 1; i >= 0; i--) begin
		if (!m_busy[i])
			free_slot = i; // lowest free slot before the edge
	end
	if (clear) begin
		model_reset();
		return;
	end
	for (int i = 0; i < TRACE_N; i++) begin
		if (m_busy[i]) begin
			if (flush && !m_disp[i]) begin
				m_busy[i] = 1'b0;
			end else if (ret && ret_id == m_id[i]) begin
				m_busy[i] = 1'b0;
				m_disp[i] = 1'b0;
			end else if (dsp && dsp_id == m_id[i]) begin
				m_disp[i] = 1'b1;
			end
		end
	end
	if (ent && !flush && free_slot >= 0) begin // enter is lost during a flush
		m_busy[free_slot] = 1'b1;
		m_disp[free_slot] = 1'b0;
		m_id[free_slot] = ent_id;
		m_rd[free_slot] = ent_rd;
		m_rd_vld[free_slot] = ent_rd_vld;
		m_long[free_slot] = ent_long;
	end
endfunction

function automatic logic model_full();
	return &m_busy;
endfunction

function automatic logic model_raw(input logic [REG_ID_WIDTH-1:0] rs);
	logic hit;
	hit = 1'b0;
	for (int i = 0; i < TRACE_N; i++) begin
		if (m_busy[i] && m_disp[i] && m_rd_vld[i] && m_rd[i] == rs)
			hit = 1'b1;
	end
	return hit && (rs != REG_ZERO);
endfunction

function automatic logic model_waw(input logic [REG_ID_WIDTH-1:0] rd);
	logic hit;
	hit = 1'b0;
	for (int i = 0; i < TRACE_N; i++) begin
		if (m_busy[i] && m_disp[i] && m_rd_vld[i] && m_long[i] && m_rd[i] == rd)
			hit = 1'b1;
	end
	return hit && (rd != REG_ZERO);
endfunction

`endif

// File: tb/tb_dpc_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dpc_monitor;
	import dpc_pkg::*;

	localparam int CLK_HALF = 5; // 10 ns period
	localparam int RESET_CYCLES = 5;
	localparam int DIRECTED_CYCLES = 120; // upper bound for the directed part
	localparam int RANDOM_CYCLES = 4000;
	localparam int WATCHDOG_NS = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES)
		* 2 * CLK_HALF + 500;

	logic                     clk;
	logic                     reset;
	logic                     sys_reset_req;
	logic                     flush_req;
	logic                     enter_valid;
	logic [INST_ID_WIDTH-1:0] enter_inst_id;
	logic [REG_ID_WIDTH-1:0]  enter_rd_id;
	logic                     enter_rd_vld;
	logic                     enter_is_long;
	logic                     dsptc_valid;
	logic [INST_ID_WIDTH-1:0] dsptc_inst_id;
	logic                     retire_valid;
	logic [INST_ID_WIDTH-1:0] retire_inst_id;
	logic [REG_ID_WIDTH-1:0]  rs1_id;
	logic [REG_ID_WIDTH-1:0]  rs2_id;
	logic [REG_ID_WIDTH-1:0]  waw_rd_id;
	logic                     rs1_raw_dpc;
	logic                     rs2_raw_dpc;
	logic                     rd_waw_dpc;
	logic                     tb_full;

	// values for the next cycle, put on the DUT pins at the rising edge
	logic                     nx_reset;
	logic                     nx_sys_reset_req;
	logic                     nx_flush_req;
	logic                     nx_enter_valid;
	logic [INST_ID_WIDTH-1:0] nx_enter_inst_id;
	logic [REG_ID_WIDTH-1:0]  nx_enter_rd_id;
	logic                     nx_enter_rd_vld;
	logic                     nx_enter_is_long;
	logic                     nx_dsptc_valid;
	logic [INST_ID_WIDTH-1:0] nx_dsptc_inst_id;
	logic                     nx_retire_valid;
	logic [INST_ID_WIDTH-1:0] nx_retire_inst_id;
	logic [REG_ID_WIDTH-1:0]  nx_rs1_id;
	logic [REG_ID_WIDTH-1:0]  nx_rs2_id;
	logic [REG_ID_WIDTH-1:0]  nx_waw_rd_id;

	int                       seed;
	logic [INST_ID_WIDTH-1:0] id_count; // next instruction id to hand out

	`include "dpc_model.svh"

	dpc_monitor i_dut (
		.clk            (clk),
		.reset          (reset),
		.sys_reset_req  (sys_reset_req),
		.flush_req      (flush_req),
		.enter_valid    (enter_valid),
		.enter_inst_id  (enter_inst_id),
		.enter_rd_id    (enter_rd_id),
		.enter_rd_vld   (enter_rd_vld),
		.enter_is_long  (enter_is_long),
		.dsptc_valid    (dsptc_valid),
		.dsptc_inst_id  (dsptc_inst_id),
		.retire_valid   (retire_valid),
		.retire_inst_id (retire_inst_id),
		.rs1_id         (rs1_id),
		.rs2_id         (rs2_id),
		.waw_rd_id      (waw_rd_id),
		.rs1_raw_dpc    (rs1_raw_dpc),
		.rs2_raw_dpc    (rs2_raw_dpc),
		.rd_waw_dpc     (rd_waw_dpc),
		.tb_full        (tb_full)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_HALF) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("simulation timed out after %0d ns before all tests finished", WATCHDOG_NS);
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, actual,
				expected);
			$display("Something failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_full(input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: tb_full is %b, expected %b", $time, actual,
				expected);
			$display("Something failed");
			$fatal(1, "mismatch on tb_full");
		end
	endtask

	// outputs against the model, every cycle
	task automatic check_outputs();
		check_full(tb_full, model_full());
		check_flag("rs1_raw_dpc", rs1_raw_dpc, model_raw(rs1_id));
		check_flag("rs2_raw_dpc", rs2_raw_dpc, model_raw(rs2_id));
		check_flag("rd_waw_dpc", rd_waw_dpc, model_waw(waw_rd_id));
	endtask

	// fixed values known from the scenario
	task automatic expect_outputs(input logic full, input logic rs1, input logic rs2,
			input logic waw);
		check_full(tb_full, full);
		check_flag("rs1_raw_dpc", rs1_raw_dpc, rs1);
		check_flag("rs2_raw_dpc", rs2_raw_dpc, rs2);
		check_flag("rd_waw_dpc", rd_waw_dpc, waw);
	endtask

	task automatic drive_inputs();
		reset <= nx_reset;
		sys_reset_req <= nx_sys_reset_req;
		flush_req <= nx_flush_req;
		enter_valid <= nx_enter_valid;
		enter_inst_id <= nx_enter_inst_id;
		enter_rd_id <= nx_enter_rd_id;
		enter_rd_vld <= nx_enter_rd_vld;
		enter_is_long <= nx_enter_is_long;
		dsptc_valid <= nx_dsptc_valid;
		dsptc_inst_id <= nx_dsptc_inst_id;
		retire_valid <= nx_retire_valid;
		retire_inst_id <= nx_retire_inst_id;
		rs1_id <= nx_rs1_id;
		rs2_id <= nx_rs2_id;
		waw_rd_id <= nx_waw_rd_id;
	endtask

	task automatic clear_strobes(); // query indices are kept
		nx_reset = 1'b0;
		nx_sys_reset_req = 1'b0;
		nx_flush_req = 1'b0;
		nx_enter_valid = 1'b0;
		nx_dsptc_valid = 1'b0;
		nx_retire_valid = 1'b0;
	endtask

	// drive at the rising edge, check at the falling edge, then step the model
	task automatic apply_cycle();
		@(posedge clk);
		drive_inputs();
		@(negedge clk);
		check_outputs();
		model_edge(reset || sys_reset_req, flush_req, enter_valid, enter_inst_id,
			enter_rd_id, enter_rd_vld, enter_is_long, dsptc_valid, dsptc_inst_id,
			retire_valid, retire_inst_id);
		clear_strobes();
	endtask

	// skips ids still held by a busy slot
	function automatic logic [INST_ID_WIDTH-1:0] fresh_id();
		logic                     used;
		logic [INST_ID_WIDTH-1:0] id;
		for (int n = 0; n < 2 ** INST_ID_WIDTH; n++) begin
			used = 1'b0;
			for (int i = 0; i < TRACE_N; i++) begin
				if (m_busy[i] && m_id[i] == id_count)
					used = 1'b1;
			end
			if (!used)
				break;
			id_count = id_count + 1'b1;
		end
		id = id_count;
		id_count = id_count + 1'b1;
		return id;
	endfunction

	// index of a randomly chosen set bit, -1 if none
	function automatic int pick_slot(input logic [TRACE_N-1:0] mask, input int sel);
		int count;
		int k;
		int idx;
		count = 0;
		idx = -1;
		for (int i = 0; i < TRACE_N; i++) begin
			if (mask[i])
				count++;
		end
		if (count == 0)
			return -1;
		k = sel % count;
		for (int i = 0; i < TRACE_N; i++) begin
			if (mask[i]) begin
				if (k == 0)
					idx = i;
				k = k - 1;
			end
		end
		return idx;
	endfunction

	task automatic stage_enter(input logic [REG_ID_WIDTH-1:0] rd, input logic rd_vld,
			input logic is_long, output logic [INST_ID_WIDTH-1:0] id);
		id = fresh_id();
		nx_enter_valid = 1'b1;
		nx_enter_inst_id = id;
		nx_enter_rd_id = rd;
		nx_enter_rd_vld = rd_vld;
		nx_enter_is_long = is_long;
	endtask

	task automatic stage_dispatch(input logic [INST_ID_WIDTH-1:0] id);
		nx_dsptc_valid = 1'b1;
		nx_dsptc_inst_id = id;
	endtask

	task automatic stage_retire(input logic [INST_ID_WIDTH-1:0] id);
		nx_retire_valid = 1'b1;
		nx_retire_inst_id = id;
	endtask

	task automatic set_queries(input logic [REG_ID_WIDTH-1:0] rs1,
			input logic [REG_ID_WIDTH-1:0] rs2, input logic [REG_ID_WIDTH-1:0] waw);
		nx_rs1_id = rs1;
		nx_rs2_id = rs2;
		nx_waw_rd_id = waw;
	endtask

	task automatic clear_table();
		nx_sys_reset_req = 1'b1;
		apply_cycle();
		apply_cycle();
		expect_outputs(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_after_reset();
		logic [31:0] rnd;
		for (int n = 0; n < 8; n++) begin
			rnd = $random(seed);
			set_queries(rnd[4:0], rnd[9:5], rnd[14:10]);
			apply_cycle();
			expect_outputs(1'b0, 1'b0, 1'b0, 1'b0);
		end
	endtask

	task automatic test_full();
		logic [INST_ID_WIDTH-1:0] ids [TRACE_N];
		set_queries(REG_ZERO, REG_ZERO, REG_ZERO);
		for (int n = 0; n < TRACE_N; n++) begin
			stage_enter(REG_ID_WIDTH'(n + 1), 1'b1, 1'b0, ids[n]);
			apply_cycle();
		end
		apply_cycle(); // last enter lands here
		expect_outputs(1'b1, 1'b0, 1'b0, 1'b0);
		stage_retire(ids[0]);
		apply_cycle();
		expect_outputs(1'b1, 1'b0, 1'b0, 1'b0); // retire not taken yet
		apply_cycle();
		expect_outputs(1'b0, 1'b0, 1'b0, 1'b0);
		clear_table();
	endtask

	task automatic test_raw_waw();
		logic [INST_ID_WIDTH-1:0] id_short;
		logic [INST_ID_WIDTH-1:0] id_long;
		logic [INST_ID_WIDTH-1:0] id_zero;
		stage_enter(5'd5, 1'b1, 1'b0, id_short);
		apply_cycle();
		stage_enter(5'd6, 1'b1, 1'b1, id_long);
		apply_cycle();
		stage_enter(REG_ZERO, 1'b1, 1'b1, id_zero);
		apply_cycle();
		stage_dispatch(id_short);
		apply_cycle();
		stage_dispatch(id_zero);
		apply_cycle();
		// x5 from a dispatched short op, x6 only from a pending long op
		set_queries(5'd5, 5'd6, 5'd5);
		apply_cycle();
		expect_outputs(1'b0, 1'b1, 1'b0, 1'b0);
		set_queries(REG_ZERO, 5'd5, 5'd6);
		apply_cycle();
		expect_outputs(1'b0, 1'b0, 1'b1, 1'b0);
		stage_dispatch(id_long);
		apply_cycle();
		set_queries(5'd6, REG_ZERO, 5'd6);
		apply_cycle();
		expect_outputs(1'b0, 1'b1, 1'b0, 1'b1);
		set_queries(5'd7, 5'd7, REG_ZERO); // x0 has a dispatched long writer
		apply_cycle();
		expect_outputs(1'b0, 1'b0, 1'b0, 1'b0);
		clear_table();
	endtask

	task automatic test_flush_sys_reset();
		logic [INST_ID_WIDTH-1:0] id_a;
		logic [INST_ID_WIDTH-1:0] id_b;
		logic [INST_ID_WIDTH-1:0] id_dropped;
		logic [INST_ID_WIDTH-1:0] ids [TRACE_N];
		stage_enter(5'd8, 1'b1, 1'b1, id_a);
		apply_cycle();
		stage_enter(5'd9, 1'b1, 1'b1, id_b);
		apply_cycle();
		stage_dispatch(id_a);
		apply_cycle();
		apply_cycle();
		nx_flush_req = 1'b1;
		stage_enter(5'd10, 1'b1, 1'b1, id_dropped); // lost with the flush
		apply_cycle();
		set_queries(5'd8, 5'd9, 5'd8);
		apply_cycle();
		expect_outputs(1'b0, 1'b1, 1'b0, 1'b1);
		// flushed and dropped ids no longer match anything
		stage_dispatch(id_b);
		apply_cycle();
		stage_dispatch(id_dropped);
		apply_cycle();
		set_queries(5'd9, 5'd10, 5'd8);
		apply_cycle();
		expect_outputs(1'b0, 1'b0, 1'b0, 1'b1);
		stage_retire(id_a);
		apply_cycle();
		expect_outputs(1'b0, 1'b0, 1'b0, 1'b1);
		set_queries(5'd8, 5'd8, 5'd8);
		apply_cycle();
		expect_outputs(1'b0, 1'b0, 1'b0, 1'b0);
		for (int n = 0; n < TRACE_N; n++) begin
			stage_enter(REG_ID_WIDTH'(11 + n), 1'b1, 1'b1, ids[n]);
			apply_cycle();
		end
		for (int n = 0; n < TRACE_N; n++) begin
			stage_dispatch(ids[n]);
			apply_cycle();
		end
		set_queries(5'd11, 5'd12, 5'd14);
		apply_cycle();
		expect_outputs(1'b1, 1'b1, 1'b1, 1'b1);
		nx_sys_reset_req = 1'b1;
		apply_cycle();
		expect_outputs(1'b1, 1'b1, 1'b1, 1'b1);
		apply_cycle();
		expect_outputs(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_random();
		logic [31:0]              rnd;
		logic [31:0]              qry;
		logic [TRACE_N-1:0]       pending;
		logic [TRACE_N-1:0]       issued;
		logic [INST_ID_WIDTH-1:0] id;
		int                       slot;
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			rnd = $random(seed);
			qry = $random(seed);
			pending = m_busy & ~m_disp;
			issued = m_busy & m_disp;
			if (rnd[0] && !(&m_busy)) // never enter into a full table
				stage_enter(REG_ID_WIDTH'(rnd[7:5]), rnd[8] | rnd[9], rnd[10], id);
			slot = pick_slot(pending, int'(rnd[15:12]));
			if (rnd[1] && slot >= 0)
				stage_dispatch(m_id[slot]);
			slot = pick_slot(issued, int'(rnd[19:16]));
			if (rnd[2] && slot >= 0)
				stage_retire(m_id[slot]);
			nx_flush_req = (rnd[23:20] == 4'd0);
			nx_sys_reset_req = (rnd[29:24] == 6'd0);
			if (qry[15])
				set_queries(qry[4:0], qry[9:5], qry[14:10]);
			else // low registers, where the writers are
				set_queries(REG_ID_WIDTH'(qry[2:0]), REG_ID_WIDTH'(qry[5:3]),
					REG_ID_WIDTH'(qry[8:6]));
			apply_cycle();
		end
	endtask

	initial begin
		seed = 32'h60ae_3254;
		id_count = '0;
		model_reset();
		clear_strobes();
		set_queries(REG_ZERO, REG_ZERO, REG_ZERO);
		nx_enter_inst_id = '0;
		nx_enter_rd_id = '0;
		nx_enter_rd_vld = 1'b0;
		nx_enter_is_long = 1'b0;
		nx_dsptc_inst_id = '0;
		nx_retire_inst_id = '0;
		nx_reset = 1'b1;
		drive_inputs(); // reset level from time zero is the first cycle
		for (int n = 1; n < RESET_CYCLES; n++) begin
			nx_reset = 1'b1;
			apply_cycle();
		end
		test_after_reset();
		test_full();
		test_raw_waw();
		test_flush_sys_reset();
		test_random();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire
